// File: logic/div_pkg.sv
package div_pkg;

    // operand and result width
    localparam int DATA_WIDTH = 8;

    // one queued request: |x|, |y|, q_neg, r_neg, div_zero, ovf
    localparam int ENTRY_W = 2 * DATA_WIDTH + 4;

    localparam int FIFO_DEPTH = 4;
    localparam int PTR_W      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    // counts 0..DATA_WIDTH, the last value is the finish step
    localparam int CNT_W = $clog2(DATA_WIDTH + 1);

    // quotient for a zero divisor
    localparam logic [DATA_WIDTH - 1 : 0] ALL_ONES = {DATA_WIDTH{1'b1}};

    // most negative signed value, dividend of the overflow case
    localparam logic [DATA_WIDTH - 1 : 0] MOST_NEG = {1'b1, {(DATA_WIDTH - 1){1'b0}}};

    // core states, one-hot
    localparam logic [2 : 0] ST_IDLE = 3'b001;
    localparam logic [2 : 0] ST_CALC = 3'b010;
    localparam logic [2 : 0] ST_OUT  = 3'b100;

endpackage

// File: logic/div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_valid,
    input  logic                                i_signed,
    input  logic [div_pkg::DATA_WIDTH - 1 : 0]  i_num_x,
    input  logic [div_pkg::DATA_WIDTH - 1 : 0]  i_num_y,
    input  logic                                i_ready,
    output logic                                o_ready,
    output logic                                o_valid,
    output logic [div_pkg::DATA_WIDTH - 1 : 0]  o_abs_x,
    output logic [div_pkg::DATA_WIDTH - 1 : 0]  o_abs_y,
    output logic                                o_q_neg,
    output logic                                o_r_neg,
    output logic                                o_div_zero,
    output logic                                o_ovf
);

    logic                               w_neg_x;
    logic                               w_neg_y;
    logic [div_pkg::DATA_WIDTH - 1 : 0] w_abs_x;
    logic [div_pkg::DATA_WIDTH - 1 : 0] w_abs_y;
    logic                               w_take;

    assign w_neg_x = i_signed & i_num_x[div_pkg::DATA_WIDTH - 1];
    assign w_neg_y = i_signed & i_num_y[div_pkg::DATA_WIDTH - 1];

    // -MOST_NEG wraps to itself, still the right unsigned magnitude
    assign w_abs_x = w_neg_x ? (~i_num_x + 1'b1) : i_num_x;
    assign w_abs_y = w_neg_y ? (~i_num_y + 1'b1) : i_num_y;

    // register empty or draining this cycle
    assign o_ready = !o_valid || i_ready;
    assign w_take  = i_valid && o_ready;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            o_valid <= 1'b0;
        end
        else if (o_ready) begin
            o_valid <= i_valid;
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_take) begin
            o_abs_x    <= w_abs_x;
            o_abs_y    <= w_abs_y;
            o_q_neg    <= w_neg_x ^ w_neg_y;
            o_r_neg    <= w_neg_x;               // remainder follows dividend
            o_div_zero <= (i_num_y == '0);
            o_ovf      <= i_signed && (i_num_x == div_pkg::MOST_NEG)
                          && (i_num_y == div_pkg::ALL_ONES);
        end
    end

    // a prepared request waits for the FIFO
    a_valid_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_valid && !i_ready |=> o_valid
    ) else $error("prep: o_valid dropped without a transfer");

endmodule

// File: logic/div_op_fifo.sv
`timescale 1ns/1ps

module div_op_fifo (
    input  logic                             i_clk,
    input  logic                             i_rst_n,
    input  logic                             i_valid,
    input  logic [div_pkg::ENTRY_W - 1 : 0]  i_data,
    input  logic                             i_ready,
    output logic                             o_ready,
    output logic                             o_valid,
    output logic [div_pkg::ENTRY_W - 1 : 0]  o_data
);

    logic [div_pkg::ENTRY_W - 1 : 0] r_mem [div_pkg::FIFO_DEPTH];

    logic [div_pkg::PTR_W - 1 : 0] r_wr_ptr;
    logic [div_pkg::PTR_W - 1 : 0] r_rd_ptr;
    logic [div_pkg::PTR_W : 0]     r_count;

    logic w_wr_en;
    logic w_rd_en;

    assign o_ready = (r_count != (div_pkg::PTR_W + 1)'(div_pkg::FIFO_DEPTH));
    assign o_valid = (r_count != '0);
    assign o_data  = r_mem[r_rd_ptr];      // head entry, no read latency

    assign w_wr_en = i_valid && o_ready;
    assign w_rd_en = i_ready && o_valid;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_wr_ptr <= '0;
            r_rd_ptr <= '0;
            r_count  <= '0;
        end
        else begin
            if (w_wr_en) begin
                if (r_wr_ptr == (div_pkg::PTR_W)'(div_pkg::FIFO_DEPTH - 1)) begin
                    r_wr_ptr <= '0;
                end
                else begin
                    r_wr_ptr <= r_wr_ptr + 1'b1;
                end
            end
            if (w_rd_en) begin
                if (r_rd_ptr == (div_pkg::PTR_W)'(div_pkg::FIFO_DEPTH - 1)) begin
                    r_rd_ptr <= '0;
                end
                else begin
                    r_rd_ptr <= r_rd_ptr + 1'b1;
                end
            end
            case ({w_wr_en, w_rd_en})
                2'b10:   r_count <= r_count + 1'b1;
                2'b01:   r_count <= r_count - 1'b1;
                default: r_count <= r_count;     // both or neither
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_wr_en) begin
            r_mem[r_wr_ptr] <= i_data;
        end
    end

    a_no_write_full: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !o_ready |=> $stable(r_wr_ptr)
    ) else $error("fifo: write while full");

    a_no_read_empty: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !o_valid |=> $stable(r_rd_ptr)
    ) else $error("fifo: read while empty");

endmodule

// File: logic/div_iter_core.sv
`timescale 1ns/1ps

module div_iter_core (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_valid,
    input  logic [div_pkg::DATA_WIDTH - 1 : 0]  i_abs_x,
    input  logic [div_pkg::DATA_WIDTH - 1 : 0]  i_abs_y,
    input  logic                                i_q_neg,
    input  logic                                i_r_neg,
    input  logic                                i_div_zero,
    input  logic                                i_ovf,
    input  logic                                i_ready,
    output logic                                o_ready,
    output logic                                o_valid,
    output logic [div_pkg::DATA_WIDTH - 1 : 0]  o_quot,
    output logic [div_pkg::DATA_WIDTH - 1 : 0]  o_rem
);

    logic [2 : 0]                     r_state;
    logic [div_pkg::CNT_W - 1 : 0]    r_cnt;
    logic                             w_last;

    // double width partial remainder and shifted divisor
    logic [div_pkg::DATA_WIDTH * 2 - 1 : 0] r_part;
    logic [div_pkg::DATA_WIDTH * 2 - 1 : 0] r_div;
    logic [div_pkg::DATA_WIDTH * 2 - 1 : 0] w_diff;
    logic [div_pkg::DATA_WIDTH - 1 : 0]     r_quot;

    logic r_q_neg;
    logic r_r_neg;
    logic r_div_zero;
    logic r_ovf;

    logic [div_pkg::DATA_WIDTH - 1 : 0] w_quot_s;
    logic [div_pkg::DATA_WIDTH - 1 : 0] w_rem_s;

    assign o_ready = (r_state == div_pkg::ST_IDLE);
    assign w_last  = (r_cnt == (div_pkg::CNT_W)'(div_pkg::DATA_WIDTH));
    assign w_diff  = r_part - r_div;     // msb set means borrow

    always_comb begin
        w_quot_s = r_q_neg ? (~r_quot + 1'b1) : r_quot;
        w_rem_s  = r_r_neg ? (~r_part[div_pkg::DATA_WIDTH - 1 : 0] + 1'b1)
                           : r_part[div_pkg::DATA_WIDTH - 1 : 0];
        // remainder path already gives the dividend back for y == 0
        if (r_div_zero) begin
            w_quot_s = div_pkg::ALL_ONES;
        end
        else if (r_ovf) begin
            w_quot_s = div_pkg::MOST_NEG;
            w_rem_s  = '0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            r_state <= div_pkg::ST_IDLE;
            r_cnt   <= '0;
            o_valid <= 1'b0;
        end
        else begin
            case (r_state)
                div_pkg::ST_IDLE: begin
                    if (i_valid) begin
                        r_state <= div_pkg::ST_CALC;
                        r_cnt   <= '0;
                    end
                end
                div_pkg::ST_CALC: begin
                    if (w_last) begin
                        r_state <= div_pkg::ST_OUT;
                        o_valid <= 1'b1;
                    end
                    else begin
                        r_cnt <= r_cnt + 1'b1;
                    end
                end
                div_pkg::ST_OUT: begin
                    if (i_ready) begin
                        r_state <= div_pkg::ST_IDLE;
                        o_valid <= 1'b0;
                    end
                end
                default: begin
                    r_state <= div_pkg::ST_IDLE;
                    o_valid <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        case (r_state)
            div_pkg::ST_IDLE: begin
                if (i_valid) begin
                    r_part     <= {{div_pkg::DATA_WIDTH{1'b0}}, i_abs_x};
                    r_div      <= {1'b0, i_abs_y, {(div_pkg::DATA_WIDTH - 1){1'b0}}};
                    r_quot     <= '0;
                    r_q_neg    <= i_q_neg;
                    r_r_neg    <= i_r_neg;
                    r_div_zero <= i_div_zero;
                    r_ovf      <= i_ovf;
                end
            end
            div_pkg::ST_CALC: begin
                if (!w_last) begin
                    r_quot <= {r_quot[div_pkg::DATA_WIDTH - 2 : 0],
                               ~w_diff[div_pkg::DATA_WIDTH * 2 - 1]};
                    r_div  <= r_div >> 1;
                    if (!w_diff[div_pkg::DATA_WIDTH * 2 - 1]) begin
                        r_part <= w_diff;        // restore by keeping old value
                    end
                end
                else begin
                    o_quot <= w_quot_s;
                    o_rem  <= w_rem_s;
                end
            end
            default: begin
            end
        endcase
    end

    a_out_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_valid && !i_ready |=> o_valid && $stable(o_quot) && $stable(o_rem)
    ) else $error("core: result changed before it was taken");

    a_cnt_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        r_cnt <= (div_pkg::CNT_W)'(div_pkg::DATA_WIDTH)
    ) else $error("core: iteration counter out of range");

endmodule

// File: logic/div_top.sv
`timescale 1ns/1ps

module div_top (
    input  logic                                i_clk,
    input  logic                                i_rst_n,
    input  logic                                i_valid,
    input  logic                                i_signed,
    input  logic [div_pkg::DATA_WIDTH - 1 : 0]  i_num_x,
    input  logic [div_pkg::DATA_WIDTH - 1 : 0]  i_num_y,
    input  logic                                i_ready,
    output logic                                o_ready,
    output logic                                o_valid,
    output logic [div_pkg::DATA_WIDTH - 1 : 0]  o_quot,
    output logic [div_pkg::DATA_WIDTH - 1 : 0]  o_rem
);

    // producer side
    logic                               p_valid;
    logic                               p_ready;
    logic [div_pkg::DATA_WIDTH - 1 : 0] p_abs_x;
    logic [div_pkg::DATA_WIDTH - 1 : 0] p_abs_y;
    logic                               p_q_neg;
    logic                               p_r_neg;
    logic                               p_div_zero;
    logic                               p_ovf;

    // fifo head
    logic                               f_valid;
    logic                               f_ready;
    logic [div_pkg::DATA_WIDTH - 1 : 0] f_abs_x;
    logic [div_pkg::DATA_WIDTH - 1 : 0] f_abs_y;
    logic                               f_q_neg;
    logic                               f_r_neg;
    logic                               f_div_zero;
    logic                               f_ovf;

    logic [div_pkg::ENTRY_W - 1 : 0] p_entry;
    logic [div_pkg::ENTRY_W - 1 : 0] f_entry;

    assign p_entry = {p_abs_x, p_abs_y, p_q_neg, p_r_neg, p_div_zero, p_ovf};
    assign {f_abs_x, f_abs_y, f_q_neg, f_r_neg, f_div_zero, f_ovf} = f_entry;

    div_operand_prep u_prep (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (i_valid),
        .i_signed   (i_signed),
        .i_num_x    (i_num_x),
        .i_num_y    (i_num_y),
        .i_ready    (p_ready),
        .o_ready    (o_ready),
        .o_valid    (p_valid),
        .o_abs_x    (p_abs_x),
        .o_abs_y    (p_abs_y),
        .o_q_neg    (p_q_neg),
        .o_r_neg    (p_r_neg),
        .o_div_zero (p_div_zero),
        .o_ovf      (p_ovf)
    );

    div_op_fifo u_fifo (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_valid (p_valid),
        .i_data  (p_entry),
        .i_ready (f_ready),
        .o_ready (p_ready),
        .o_valid (f_valid),
        .o_data  (f_entry)
    );

    div_iter_core u_core (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_valid    (f_valid),
        .i_abs_x    (f_abs_x),
        .i_abs_y    (f_abs_y),
        .i_q_neg    (f_q_neg),
        .i_r_neg    (f_r_neg),
        .i_div_zero (f_div_zero),
        .i_ovf      (f_ovf),
        .i_ready    (i_ready),
        .o_ready    (f_ready),
        .o_valid    (o_valid),
        .o_quot     (o_quot),
        .o_rem      (o_rem)
    );

endmodule

// File: tb/div_model.svh
`ifndef DIV_MODEL_SVH
`define DIV_MODEL_SVH

// expected {quotient, remainder} for one request
function automatic logic [2 * div_pkg::DATA_WIDTH - 1 : 0] div_model(
    input logic                               is_signed,
    input logic [div_pkg::DATA_WIDTH - 1 : 0] x,
    input logic [div_pkg::DATA_WIDTH - 1 : 0] y
);
    int a;
    int b;
    int q;
    int r;
    if (is_signed) begin
        a = int'($signed(x));
        b = int'($signed(y));
    end
    else begin
        a = int'(x);
        b = int'(y);
    end
    if (b == 0) begin
        return {div_pkg::ALL_ONES, x};     // remainder is the dividend
    end
    // most negative over minus one
    if (is_signed && (a == -(1 << (div_pkg::DATA_WIDTH - 1))) && (b == -1)) begin
        return {x, {div_pkg::DATA_WIDTH{1'b0}}};
    end
    q = a / b;      // truncates toward zero
    r = a % b;      // sign of the dividend
    return {q[div_pkg::DATA_WIDTH - 1 : 0], r[div_pkg::DATA_WIDTH - 1 : 0]};
endfunction

`endif

// File: tb/tb_div_top.sv
`timescale 1ns/1ps

module tb_div_top;

    localparam int W     = div_pkg::DATA_WIDTH;
    localparam int N_UNS = 40;
    localparam int N_SGN = 60;
    localparam int N_SPC = 16;
    localparam int N_BP  = 48;
    localparam int LIMIT = 24 * (N_UNS + N_SGN + N_SPC + N_BP) + 400;
    localparam int DRAIN = 24 * (div_pkg::FIFO_DEPTH + 2);    // prep, FIFO and core all full

    logic           i_clk = 1'b0;
    logic           i_rst_n;
    logic           i_valid;
    logic           i_signed;
    logic [W - 1:0] i_num_x;
    logic [W - 1:0] i_num_y;
    logic           i_ready;
    logic           o_ready;
    logic           o_valid;
    logic [W - 1:0] o_quot;
    logic [W - 1:0] o_rem;

    logic [4 * W : 0] exp_q[$];      // {signed, x, y, quot, rem}
    logic [2 * W : 0] bp_req[$];     // {signed, x, y}
    logic             bp_rdy[$];

    int seed;
    int rnd;
    int rdy_mode = 0;                // 0 high, 1 random, 2 low
    int rdy_idx  = 0;
    int rd_idx   = 0;
    int err_cmp  = 0;
    int err_main = 0;
    int cyc      = 0;

    logic           saw_ready_low = 1'b0;
    logic           hold_pending  = 1'b0;
    logic [W - 1:0] hold_quot;
    logic [W - 1:0] hold_rem;
    logic           e_s;
    logic [W - 1:0] e_x;
    logic [W - 1:0] e_y;
    logic [W - 1:0] e_q;
    logic [W - 1:0] e_r;

    `include "div_model.svh"

    div_top dut (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_valid  (i_valid),
        .i_signed (i_signed),
        .i_num_x  (i_num_x),
        .i_num_y  (i_num_y),
        .i_ready  (i_ready),
        .o_ready  (o_ready),
        .o_valid  (o_valid),
        .o_quot   (o_quot),
        .o_rem    (o_rem)
    );

    always #20 i_clk = ~i_clk;

    task automatic check_idle();
        if (o_valid !== 1'b0) begin
            $display("CHECK FAILED o_valid: expected %h, got %h", 1'b0, o_valid);
            err_main++;
        end
        if (o_ready !== 1'b1) begin
            $display("CHECK FAILED o_ready: expected %h, got %h", 1'b1, o_ready);
            err_main++;
        end
    endtask

    // called on a falling edge and returns on the falling edge after the transfer
    task automatic send_req(input logic s, input logic [W - 1:0] x, input logic [W - 1:0] y);
        logic taken;
        taken    = 1'b0;
        i_valid  = 1'b1;
        i_signed = s;
        i_num_x  = x;
        i_num_y  = y;
        while (!taken) begin
            taken = o_ready;         // o_ready only moves after a rising edge
            @(negedge i_clk);
        end
        exp_q.push_back({s, x, y, div_model(s, x, y)});
        i_valid = 1'b0;
    endtask

    task automatic wait_drain(input int max_cyc);
        int n;
        n = 0;
        while ((rd_idx < exp_q.size()) && (n < max_cyc)) begin
            @(negedge i_clk);
            n++;
        end
    endtask

    task automatic set_ready_mode(input int m);
        @(posedge i_clk);
        rdy_mode = m;
        @(negedge i_clk);
    endtask

    initial begin
        i_ready = 1'b1;
        forever begin
            @(negedge i_clk);
            if (rdy_mode == 2 && !o_ready) begin
                saw_ready_low = 1'b1;
            end
            case (rdy_mode)
                1: begin
                    i_ready = bp_rdy[rdy_idx % bp_rdy.size()];
                    rdy_idx++;
                end
                2:       i_ready = 1'b0;
                default: i_ready = 1'b1;
            endcase
        end
    end

    // compare on each output transfer and watch held results
    always @(posedge i_clk) begin
        if (i_rst_n) begin
            if (hold_pending) begin
                if (!o_valid) begin
                    $display("CHECK FAILED o_valid: expected %h, got %h", 1'b1, o_valid);
                    err_cmp++;
                end
                if (o_quot !== hold_quot) begin
                    $display("CHECK FAILED o_quot: expected %h, got %h", hold_quot, o_quot);
                    err_cmp++;
                end
                if (o_rem !== hold_rem) begin
                    $display("CHECK FAILED o_rem: expected %h, got %h", hold_rem, o_rem);
                    err_cmp++;
                end
            end
            if (o_valid && i_ready) begin
                if (rd_idx >= exp_q.size()) begin
                    $display("result quot %h rem %h arrived with no request outstanding",
                             o_quot, o_rem);
                    err_cmp++;
                end
                else begin
                    {e_s, e_x, e_y, e_q, e_r} = exp_q[rd_idx];
                    rd_idx++;
                    if (o_quot !== e_q) begin
                        $display("CHECK FAILED o_quot: expected %h, got %h (s %h x %h y %h)",
                                 e_q, o_quot, e_s, e_x, e_y);
                        err_cmp++;
                    end
                    if (o_rem !== e_r) begin
                        $display("CHECK FAILED o_rem: expected %h, got %h (s %h x %h y %h)",
                                 e_r, o_rem, e_s, e_x, e_y);
                        err_cmp++;
                    end
                end
            end
            hold_pending = o_valid && !i_ready;
            hold_quot    = o_quot;
            hold_rem     = o_rem;
        end
    end

    always @(posedge i_clk) begin
        cyc++;
        if (cyc >= LIMIT) begin
            $display("timeout after %0d cycles, %0d of %0d results received",
                     cyc, rd_idx, exp_q.size());
            $display("Errors found");
            $finish;
        end
    end

    initial begin
        seed     = 31719;
        i_rst_n  = 1'b0;
        i_valid  = 1'b0;
        i_signed = 1'b0;
        i_num_x  = '0;
        i_num_y  = '0;
        repeat (16) begin
            @(negedge i_clk);
            check_idle();
        end
        i_rst_n = 1'b1;
        repeat (2) begin
            @(negedge i_clk);
            check_idle();
        end

        for (int i = 0; i < N_UNS; i++) begin
            rnd = $random(seed);
            send_req(1'b0, rnd[W - 1:0], rnd[2 * W - 1:W]);
        end
        wait_drain(DRAIN);

        // sign bits walk through all four combinations
        for (int i = 0; i < N_SGN; i++) begin
            rnd = $random(seed);
            send_req(1'b1, {i[1], rnd[W - 2:0]}, {i[0], rnd[2 * W - 2:W]});
        end
        wait_drain(DRAIN);

        send_req(1'b0, 8'h37, 8'h00);
        send_req(1'b1, 8'h37, 8'h00);
        send_req(1'b1, 8'h85, 8'h00);
        send_req(1'b0, 8'h85, 8'h00);
        send_req(1'b1, 8'h00, 8'h00);
        send_req(1'b0, 8'hff, 8'h00);
        send_req(1'b1, 8'h80, 8'hff);    // overflow
        send_req(1'b0, 8'h80, 8'hff);
        send_req(1'b1, 8'h80, 8'h01);
        send_req(1'b1, 8'h9c, 8'h01);
        send_req(1'b0, 8'hff, 8'h01);
        send_req(1'b1, 8'h00, 8'hf3);
        send_req(1'b0, 8'h00, 8'h07);
        send_req(1'b1, 8'h80, 8'h80);
        send_req(1'b1, 8'h7f, 8'hff);
        send_req(1'b1, 8'h81, 8'h7f);
        wait_drain(DRAIN);

        for (int i = 0; i < N_BP; i++) begin
            rnd = $random(seed);
            bp_req.push_back({rnd[2 * W], rnd[2 * W - 1:0]});
        end
        for (int i = 0; i < 256; i++) begin
            rnd = $random(seed);
            bp_rdy.push_back(rnd[1:0] != 2'b00);     // low about a quarter of the time
        end
        fork
            for (int i = 0; i < N_BP; i++) begin
                send_req(bp_req[i][2 * W], bp_req[i][2 * W - 1:W], bp_req[i][W - 1:0]);
            end
            begin
                set_ready_mode(2);
                repeat (60) @(negedge i_clk);
                set_ready_mode(1);
            end
        join
        wait_drain(DRAIN);
        set_ready_mode(0);
        if (!saw_ready_low) begin
            $display("o_ready never fell while i_ready was held low");
            err_main++;
        end

        repeat (30) @(negedge i_clk);    // catch any extra result
        if (rd_idx != exp_q.size()) begin
            $display("%0d expected results never arrived", exp_q.size() - rd_idx);
            err_main++;
        end
        $display("requests %0d, result errors %0d, other errors %0d",
                 exp_q.size(), err_cmp, err_main);
        if (err_cmp + err_main == 0) begin
            $display("No errors");
        end
        else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+tb
logic/div_pkg.sv
logic/div_operand_prep.sv
logic/div_op_fifo.sv
logic/div_iter_core.sv
logic/div_top.sv
tb/tb_div_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the divider testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_div_top \
    -o tb_div_top_sim \
    || { echo "build failed"; exit 1; }

./obj_dir/tb_div_top_sim > sim.log 2>&1 \
    || echo "simulator exited with an error status"

grep -qx "No errors" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
